//--- compile.f
+incdir+include
logic/imu_pkg.sv
logic/apb_pkg.sv
logic/async_receiver.sv
logic/imu_frame_parser.sv
logic/imu_apb_regs.sv
logic/imu_sensor_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_imu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f compile.f --top-module tb_imu -Mdir obj_dir

out=$(./obj_dir/Vtb_imu)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

//--- bench/tb_imu.sv
`timescale 1ns/1ps
`include "imu_consts.svh"

module tb_imu;

  localparam int CLKS_PER_BIT = 16;
  localparam int POLL_LIMIT   = 20;  // status reads per frame

  logic               clk_uart;
  logic               rst;
  logic               wireless_tx;
  logic               wireless_rx;
  logic               wireless_set;
  apb_pkg::apb_req_t  apb_req;
  apb_pkg::apb_resp_t apb_resp;
  logic               check_en;
  logic               timed_out;
  int                 error_count;
  logic [31:0]        lfsr;
  logic [15:0]        exp_accel;
  logic [15:0]        exp_angle;
  logic [7:0]         exp_good;
  logic [7:0]         exp_bad;
  logic [7:0]         frame [`IMU_MSG_LEN];

  tb_clock #(.PERIOD_NS (20)) u_clock (.clk (clk_uart));

  imu_sensor_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_imu_sensor_top (
    .clk_uart     (clk_uart),
    .rst          (rst),
    .wireless_tx  (wireless_tx),
    .wireless_rx  (wireless_rx),
    .wireless_set (wireless_set),
    .apb_req      (apb_req),
    .apb_resp     (apb_resp)
  );

  tb_checker u_checker (
    .clk_uart     (clk_uart),
    .rst          (rst),
    .check_en     (check_en),
    .apb_req      (apb_req),
    .apb_resp     (apb_resp),
    .wireless_rx  (wireless_rx),
    .wireless_set (wireless_set),
    .exp_accel    (exp_accel),
    .exp_angle    (exp_angle),
    .exp_status   ({exp_bad, exp_good}),
    .error_count  (error_count)
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b    = {b[6:0], lfsr[0]};  // one step per bit
    end
  endtask

  function automatic logic [7:0] frame_sum();
    logic [7:0] sum;
    sum = 8'h00;
    for (int i = 0; i < `IMU_MSG_LEN - 1; i++) sum = sum + frame[i];
    return sum;
  endfunction

  // reference model, expected registers once frame[] has been received
  function automatic void expect_frame();
    if (frame[`IMU_MSG_LEN - 1] != frame_sum()) begin
      if (exp_bad != 8'hff) exp_bad = exp_bad + 8'd1;
    end else begin
      if (exp_good != 8'hff) exp_good = exp_good + 8'd1;
      if (frame[1] == `IMU_ACC_TYPE) exp_accel = {frame[3], frame[2]};  // x axis
      if (frame[1] == `IMU_ANG_TYPE) exp_angle = {frame[5], frame[4]};  // y axis
    end
  endfunction

  task automatic build_frame(input logic [7:0] kind, input logic corrupt);
    logic [7:0] b;
    frame[0] = `IMU_HEADER;
    frame[1] = kind;
    for (int i = 2; i < `IMU_MSG_LEN - 1; i++) begin
      rand_byte(b);
      frame[i] = b;
    end
    frame[`IMU_MSG_LEN - 1] = corrupt ? ~frame_sum() : frame_sum();
  endtask

  task automatic send_bit(input logic v);
    @(posedge clk_uart);
    #2 wireless_tx = v;
    repeat (CLKS_PER_BIT - 1) @(posedge clk_uart);
  endtask

  task automatic send_byte(input logic [7:0] b);
    send_bit(1'b0);  // start
    for (int i = 0; i < 8; i++) send_bit(b[i]);
    send_bit(1'b1);  // stop
  endtask

  // setup cycle, access cycle, read data taken mid access cycle
  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk_uart);
    #2 apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk_uart);
    #2 apb_req.penable = 1'b1;
    @(negedge clk_uart);
    rdata = apb_resp.prdata;
    @(posedge clk_uart);
    #2 apb_req = '0;
  endtask

  task automatic check_regs();
    logic [31:0] rdata;
    check_en = 1'b1;
    apb_access(1'b0, `IMU_REG_ACCEL, 32'd0, rdata);
    apb_access(1'b0, `IMU_REG_ANGLE, 32'd0, rdata);
    apb_access(1'b0, `IMU_REG_STATUS, 32'd0, rdata);
    check_en = 1'b0;
  endtask

  task automatic wait_status(input string name);
    logic [31:0] rdata;
    int          polls;
    polls = 0;
    rdata = {16'h0000, exp_bad, exp_good};
    while (rdata[15:0] == {exp_bad, exp_good} && polls < POLL_LIMIT) begin
      apb_access(1'b0, `IMU_REG_STATUS, 32'd0, rdata);
      polls++;
    end
    if (rdata[15:0] == {exp_bad, exp_good}) begin
      timed_out = 1'b1;
      $display("timeout: frame %s never completed, STATUS stayed at %h", name, rdata[15:0]);
    end
  endtask

  task automatic run_frame(input string name, input logic [7:0] kind, input logic corrupt);
    if (timed_out) return;
    build_frame(kind, corrupt);
    for (int i = 0; i < `IMU_MSG_LEN; i++) send_byte(frame[i]);
    wait_status(name);
    if (timed_out) return;
    expect_frame();
    check_regs();
  endtask

  initial begin
    logic [7:0]  noise;
    logic [31:0] rdata;
    rst         = 1'b1;
    wireless_tx = 1'b1;  // line idles high
    apb_req     = '0;
    check_en    = 1'b0;
    timed_out   = 1'b0;
    lfsr        = 32'h7a7d;
    exp_accel   = '0;
    exp_angle   = '0;
    exp_good    = '0;
    exp_bad     = '0;
    repeat (16) @(posedge clk_uart);
    #2 rst = 1'b0;

    check_regs();
    u_checker.end_test("reset values");

    for (int n = 0; n < 4; n++) run_frame($sformatf("accel %0d", n), `IMU_ACC_TYPE, 1'b0);
    for (int n = 0; n < 4; n++) run_frame($sformatf("angle %0d", n), `IMU_ANG_TYPE, 1'b0);
    u_checker.end_test("accel and angle frames");

    run_frame("bad accel", `IMU_ACC_TYPE, 1'b1);
    run_frame("bad angle", `IMU_ANG_TYPE, 1'b1);
    u_checker.end_test("corrupted checksum");

    for (int n = 0; n < 6; n++) begin
      rand_byte(noise);
      if (noise == `IMU_HEADER) noise = 8'h54;  // keep the parser idle
      send_byte(noise);
    end
    run_frame("accel after noise", `IMU_ACC_TYPE, 1'b0);
    run_frame("type 0x52", 8'h52, 1'b0);
    run_frame("angle after type 0x52", `IMU_ANG_TYPE, 1'b0);
    u_checker.end_test("resync");

    check_en = 1'b1;
    apb_access(1'b1, `IMU_REG_STATUS, 32'hdead_beef, rdata);
    check_en = 1'b0;
    exp_good = 8'd0;  // any write clears both counts
    exp_bad  = 8'd0;
    check_regs();
    check_en = 1'b1;
    apb_access(1'b0, 8'h0c, 32'd0, rdata);  // unmapped
    check_en = 1'b0;
    u_checker.end_test("status clear and decode");

    u_checker.report_totals();
    if (timed_out || error_count != 0) begin
      $display("Verification failed");
    end else begin
      $display("Verification passed");
    end
    $finish;
  end

endmodule

//--- bench/tb_checker.sv
`timescale 1ns/1ps
`include "imu_consts.svh"

module tb_checker (
  input  logic               clk_uart,
  input  logic               rst,
  input  logic               check_en,    // compare the current access
  input  apb_pkg::apb_req_t  apb_req,
  input  apb_pkg::apb_resp_t apb_resp,
  input  logic               wireless_rx,
  input  logic               wireless_set,
  input  logic [15:0]        exp_accel,
  input  logic [15:0]        exp_angle,
  input  logic [15:0]        exp_status,  // bad count 15:8, good count 7:0
  output int                 error_count
);

  int   errors = 0;
  int   checks = 0;
  int   tests = 0;
  int   errors_before = 0;  // totals at the end of the last test
  int   checks_before = 0;
  logic pins_bad = 1'b0;    // radio pin error already shown

  assign error_count = errors;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s at offset %h: got %h, expected %h", name, apb_req.paddr, got, exp);
    end
  endtask

  // mid-cycle sample of every access cycle
  always @(negedge clk_uart) begin
    logic [31:0] exp_data;
    logic        exp_err;
    if (!rst && check_en && apb_req.psel && apb_req.penable) begin
      exp_err  = 1'b0;
      exp_data = '0;
      case (apb_req.paddr)
        `IMU_REG_ACCEL:  exp_data = {16'h0000, exp_accel};
        `IMU_REG_ANGLE:  exp_data = {16'h0000, exp_angle};
        `IMU_REG_STATUS: exp_data = {16'h0000, exp_status};
        default:         exp_err = 1'b1;  // unmapped offset
      endcase
      compare_value("pready", {31'd0, apb_resp.pready}, 32'd1);  // no wait states
      compare_value("pslverr", {31'd0, apb_resp.pslverr}, {31'd0, exp_err});
      if (!exp_err && !apb_req.pwrite) compare_value("prdata", apb_resp.prdata, exp_data);
    end
    if (!rst && !pins_bad && (wireless_rx !== 1'b1 || wireless_set !== 1'b1)) begin
      pins_bad = 1'b1;
      errors++;
      $display("[FAIL] wireless_rx %h, wireless_set %h, expected 1 and 1",
               wireless_rx, wireless_set);
    end
  end

  task automatic end_test(input string name);
    tests++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok, %0d checks", tests, name, checks - checks_before);
    end else begin
      $display("test %0d %s: %0d errors in %0d checks", tests, name,
               errors - errors_before, checks - checks_before);
    end
    errors_before = errors;
    checks_before = checks;
  endtask

  task automatic report_totals();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
  endtask

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;  // 50 percent duty

endmodule

//--- logic/imu_sensor_top.sv
`timescale 1ns/1ps

module imu_sensor_top #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic               clk_uart,
  input  logic               rst,
  input  logic               wireless_tx,   // sensor serial stream
  output logic               wireless_rx,
  output logic               wireless_set,
  input  apb_pkg::apb_req_t  apb_req,
  output apb_pkg::apb_resp_t apb_resp
);

  imu_pkg::rx_byte_t     rx_byte;
  imu_pkg::imu_sample_t  sample;
  imu_pkg::frame_event_t frame_evt;

  async_receiver #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_async_receiver (
    .clk_uart (clk_uart),
    .rst      (rst),
    .rx       (wireless_tx),  // radio tx feeds our rx
    .rx_byte  (rx_byte)
  );

  imu_frame_parser u_imu_frame_parser (
    .clk_uart  (clk_uart),
    .rst       (rst),
    .rx_byte   (rx_byte),
    .sample    (sample),
    .frame_evt (frame_evt)
  );

  imu_apb_regs u_imu_apb_regs (
    .clk_uart  (clk_uart),
    .rst       (rst),
    .sample    (sample),
    .frame_evt (frame_evt),
    .apb_req   (apb_req),
    .apb_resp  (apb_resp)
  );

  assign wireless_rx  = 1'b1;  // nothing is sent, line idles high
  assign wireless_set = 1'b1;  // keeps the radio out of command mode

endmodule

//--- logic/imu_apb_regs.sv
`timescale 1ns/1ps
`include "imu_consts.svh"

module imu_apb_regs (
  input  logic                  clk_uart,
  input  logic                  rst,
  input  imu_pkg::imu_sample_t  sample,
  input  imu_pkg::frame_event_t frame_evt,
  input  apb_pkg::apb_req_t     apb_req,
  output apb_pkg::apb_resp_t    apb_resp
);

  logic        access;     // apb access phase
  logic        status_wr;
  logic        addr_ok;
  logic [31:0] rdata;
  logic [7:0]  good_cnt;
  logic [7:0]  bad_cnt;

  assign access    = apb_req.psel && apb_req.penable;
  assign status_wr = access && apb_req.pwrite && (apb_req.paddr == `IMU_REG_STATUS);

  // frame counters, both stick at 255
  always_ff @(posedge clk_uart) begin
    if (rst) begin
      good_cnt <= '0;
      bad_cnt  <= '0;
    end else if (status_wr) begin
      good_cnt <= '0;  // clear wins over a same-cycle event
      bad_cnt  <= '0;
    end else begin
      if (frame_evt.good && good_cnt != 8'hff) good_cnt <= good_cnt + 1'b1;
      if (frame_evt.bad && bad_cnt != 8'hff) bad_cnt <= bad_cnt + 1'b1;
    end
  end

  always_comb begin
    addr_ok = 1'b1;
    rdata   = '0;
    case (apb_req.paddr)
      `IMU_REG_ACCEL:  rdata = {16'h0000, sample.accel};
      `IMU_REG_ANGLE:  rdata = {16'h0000, sample.angle};
      `IMU_REG_STATUS: rdata = {16'h0000, bad_cnt, good_cnt};
      default:         addr_ok = 1'b0;
    endcase
  end

  assign apb_resp.prdata  = rdata;
  assign apb_resp.pready  = 1'b1;  // no wait states
  assign apb_resp.pslverr = access && !addr_ok;

  // the host must hold psel from the setup cycle into the access cycle
  a_apb_phase: assert property (
    @(posedge clk_uart) disable iff (rst)
    apb_req.penable |-> apb_req.psel && $past(apb_req.psel)
  ) else $error("penable without a setup cycle");

endmodule

//--- logic/imu_frame_parser.sv
`timescale 1ns/1ps
`include "imu_consts.svh"

module imu_frame_parser #(
  parameter int ACC_AXIS = 0,  // x
  parameter int ANG_AXIS = 1   // y
) (
  input  logic                  clk_uart,
  input  logic                  rst,
  input  imu_pkg::rx_byte_t     rx_byte,
  output imu_pkg::imu_sample_t  sample,
  output imu_pkg::frame_event_t frame_evt
);

  // byte positions of the selected words, low byte first
  localparam logic [3:0] ACC_LO   = 4'(ACC_AXIS * 2 + 2);
  localparam logic [3:0] ACC_HI   = 4'(ACC_AXIS * 2 + 3);
  localparam logic [3:0] ANG_LO   = 4'(ANG_AXIS * 2 + 2);
  localparam logic [3:0] ANG_HI   = 4'(ANG_AXIS * 2 + 3);
  localparam logic [3:0] LAST_IDX = 4'(`IMU_MSG_LEN - 1);

  if (ACC_AXIS < 0 || ACC_AXIS > 3 || ANG_AXIS < 0 || ANG_AXIS > 3) begin : g_axis_check
    $error("axis parameters must be in 0..3");
  end

  logic [3:0]  byte_idx;  // index of the next byte
  logic [7:0]  msg_type;
  logic [7:0]  checksum;  // running sum of header, type and data
  logic [15:0] acc_buf;
  logic [15:0] ang_buf;

  always_ff @(posedge clk_uart) begin
    if (rst) begin
      byte_idx  <= '0;
      sample    <= '0;
      frame_evt <= '0;
    end else begin
      frame_evt <= '0;
      if (rx_byte.valid) begin
        if (byte_idx == 4'd0) begin
          if (rx_byte.data == `IMU_HEADER) byte_idx <= 4'd1;  // skip anything else
        end else if (byte_idx == 4'd1) begin
          msg_type <= rx_byte.data;
          checksum <= `IMU_HEADER + rx_byte.data;
          byte_idx <= 4'd2;
        end else if (byte_idx == LAST_IDX) begin
          byte_idx <= '0;
          if (checksum == rx_byte.data) begin
            frame_evt.good <= 1'b1;
            if (msg_type == `IMU_ACC_TYPE) sample.accel <= acc_buf;
            if (msg_type == `IMU_ANG_TYPE) sample.angle <= ang_buf;
          end else begin
            frame_evt.bad <= 1'b1;
          end
        end else begin
          byte_idx <= byte_idx + 1'b1;
          checksum <= checksum + rx_byte.data;
        end
      end
    end
  end

  // word capture for the frame in progress
  always_ff @(posedge clk_uart) begin
    if (rx_byte.valid && msg_type == `IMU_ACC_TYPE) begin
      if (byte_idx == ACC_LO) acc_buf[7:0]  <= rx_byte.data;
      if (byte_idx == ACC_HI) acc_buf[15:8] <= rx_byte.data;
    end
    if (rx_byte.valid && msg_type == `IMU_ANG_TYPE) begin
      if (byte_idx == ANG_LO) ang_buf[7:0]  <= rx_byte.data;
      if (byte_idx == ANG_HI) ang_buf[15:8] <= rx_byte.data;
    end
  end

  // an event only ever follows a received checksum byte, and never both kinds
  a_evt_after_byte: assert property (
    @(posedge clk_uart) disable iff (rst)
    (frame_evt.good || frame_evt.bad) |->
      $past(rx_byte.valid) && !(frame_evt.good && frame_evt.bad)
  ) else $error("frame_evt without checksum byte or with both bits set");

endmodule

//--- logic/async_receiver.sv
`timescale 1ns/1ps

module async_receiver #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic              clk_uart,
  input  logic              rst,
  input  logic              rx,
  output imu_pkg::rx_byte_t rx_byte
);

  localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } rx_state_t;

  rx_state_t        state;
  logic             rx_meta;
  logic             rx_sync;
  logic [CNT_W-1:0] clk_cnt;    // clocks within the current bit
  logic [2:0]       bit_idx;
  logic [7:0]       shift_reg;  // lsb arrives first
  logic             byte_valid;

  // two flops against metastability, idle level is high
  always_ff @(posedge clk_uart) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk_uart) begin
    if (rst) begin
      state      <= S_IDLE;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      clk_cnt    <= clk_cnt + 1'b1;
      case (state)
        S_IDLE: begin
          clk_cnt <= '0;
          if (!rx_sync) state <= S_START;  // falling start edge
        end
        S_START: begin
          if (clk_cnt == HALF_LAST) begin  // middle of start bit
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? S_IDLE : S_DATA;  // glitch goes back to idle
          end
        end
        S_DATA: begin
          if (clk_cnt == BIT_LAST) begin
            clk_cnt   <= '0;
            shift_reg <= {rx_sync, shift_reg[7:1]};
            bit_idx   <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= S_STOP;
          end
        end
        S_STOP: begin
          if (clk_cnt == BIT_LAST) begin
            byte_valid <= rx_sync;  // low stop bit drops the byte
            state      <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign rx_byte.valid = byte_valid;
  assign rx_byte.data  = shift_reg;

  // a byte takes ten bit times, so the strobe can never repeat
  a_valid_single: assert property (
    @(posedge clk_uart) disable iff (rst) rx_byte.valid |=> !rx_byte.valid
  ) else $error("rx_byte.valid high for two cycles");

endmodule

//--- logic/apb_pkg.sv
package apb_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;   // byte offset
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_resp_t;

endpackage

//--- logic/imu_pkg.sv
package imu_pkg;

  // one byte out of the uart receiver
  typedef struct packed {
    logic       valid;  // single-cycle pulse
    logic [7:0] data;
  } rx_byte_t;

  // last accepted words from the sensor
  typedef struct packed {
    logic [15:0] accel;  // selected accel axis
    logic [15:0] angle;  // selected angle axis
  } imu_sample_t;

  // end of frame, at most one bit set
  typedef struct packed {
    logic good;  // checksum matched
    logic bad;   // checksum mismatch
  } frame_event_t;

endpackage

//--- include/imu_consts.svh
`ifndef IMU_CONSTS_SVH
`define IMU_CONSTS_SVH

// frame layout of the sensor's serial protocol
`define IMU_HEADER      8'h55
`define IMU_MSG_LEN     11     // header, type, 8 data bytes, checksum

// frame type codes
`define IMU_ACC_TYPE    8'h51  // acceleration
`define IMU_ANG_TYPE    8'h53  // angle

// apb byte offsets
`define IMU_REG_ACCEL   8'h00
`define IMU_REG_ANGLE   8'h04
`define IMU_REG_STATUS  8'h08  // good count 7:0, bad count 15:8

`endif
